// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0] inst_t;

  // one instruction offered to the issuer
  typedef struct packed {
    addr_t pc;
    addr_t next_pc;
    inst_t inst;
  } fetch_pkt_t;

  // redirect from the reorder buffer bus
  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

  // RV32I major opcodes in bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_INTERACTING
  } fetch_state_e;

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

  localparam int MEM_ADDR_W = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_BITS = LINE_WORDS * 32;
  // byte offset inside one cache line
  localparam int LINE_OFFSET_BITS = $clog2(LINE_WORDS * 4);

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // word k of a line lives in bits 32k and up
  typedef logic [LINE_BITS-1:0] line_t;

  // low LINE_OFFSET_BITS of addr are always zero
  typedef struct packed {
    mem_addr_t addr;
  } line_req_t;

  typedef struct packed {
    line_t line;
  } line_resp_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    mem_addr_t araddr;
  } axi_ar_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_r_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_ADDR,
    MEM_DATA
  } mem_state_e;

endpackage

// ==== fetch_frontend.f ====
common/cpu_pkg.sv
common/mem_pkg.sv
inst_fetcher/icache_store.sv
inst_fetcher/inst_fetcher.sv
src/br_predictor.sv
src/mem_ctrler.sv
src/fetch_frontend.sv
tb/fetch_frontend_assert.sv
tb/tb_fetch_frontend.sv

// ==== inst_fetcher/icache_store.sv ====
module icache_store
  import cpu_pkg::*;
  import mem_pkg::*;
#(
  parameter int CACHE_INDEX_BITS = 3
) (
  input  logic  clk,
  input  logic  reset_from_rob_bus,
  input  addr_t lookup_pc,
  output logic  hit,
  output inst_t hit_inst,
  input  logic  fill_valid,
  input  addr_t fill_addr,
  input  line_t fill_line
);

  localparam int ADDR_W = $bits(addr_t);
  localparam int NUM_LINES = 1 << CACHE_INDEX_BITS;
  localparam int TAG_W = ADDR_W - LINE_OFFSET_BITS - CACHE_INDEX_BITS;
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);

  logic [TAG_W-1:0]     tag_mem [NUM_LINES];
  line_t                line_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid_bits;

  logic [CACHE_INDEX_BITS-1:0] lookup_index;
  logic [TAG_W-1:0]            lookup_tag;
  logic [WORD_SEL_W-1:0]       word_sel;
  logic [CACHE_INDEX_BITS-1:0] fill_index;
  logic [TAG_W-1:0]            fill_tag;

  assign lookup_index = lookup_pc[LINE_OFFSET_BITS +: CACHE_INDEX_BITS];
  assign lookup_tag = lookup_pc[ADDR_W-1 -: TAG_W];
  assign word_sel = lookup_pc[LINE_OFFSET_BITS-1:2];

  assign fill_index = fill_addr[LINE_OFFSET_BITS +: CACHE_INDEX_BITS];
  assign fill_tag = fill_addr[ADDR_W-1 -: TAG_W];

  assign hit = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  // word k of the line is at bit 32k
  assign hit_inst = line_mem[lookup_index][{word_sel, 5'd0} +: 32];

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      valid_bits <= '0;
    end else if (fill_valid) begin
      valid_bits[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid) begin
      tag_mem[fill_index] <= fill_tag;
      line_mem[fill_index] <= fill_line;
    end
  end

endmodule

// ==== inst_fetcher/inst_fetcher.sv ====
module inst_fetcher
  import cpu_pkg::*;
  import mem_pkg::*;
#(
  parameter int    CACHE_INDEX_BITS = 3,
  parameter addr_t RESET_PC = '0
) (
  input  logic       clk,
  input  logic       reset_from_rob_bus,
  input  redirect_t  redirect,
  output logic       fetch_valid,
  output fetch_pkt_t fetch_pkt,
  input  logic       fetch_ready,
  output addr_t      pred_pc,
  output inst_t      pred_inst,
  input  addr_t      pred_next_pc,
  output addr_t      lookup_pc,
  input  logic       hit,
  input  inst_t      hit_inst,
  output logic       fill_valid,
  output addr_t      fill_addr,
  output line_t      fill_line,
  output logic       line_req_valid,
  output line_req_t  line_req,
  input  logic       line_resp_valid,
  input  line_resp_t line_resp
);

  localparam int ADDR_W = $bits(addr_t);
  localparam int TAG_W = ADDR_W - LINE_OFFSET_BITS - CACHE_INDEX_BITS;

  fetch_state_e state;
  addr_t        pc;
  // line address of the refill in flight
  addr_t        req_addr;
  addr_t        pc_line_base;
  logic         pc_in_line;

  assign pc_line_base = {pc[ADDR_W-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

  // pc still lies in the requested line when set and tag both match
  assign pc_in_line =
    (pc[LINE_OFFSET_BITS +: CACHE_INDEX_BITS] == req_addr[LINE_OFFSET_BITS +: CACHE_INDEX_BITS])
    && (pc[ADDR_W-1 -: TAG_W] == req_addr[ADDR_W-1 -: TAG_W]);

  assign lookup_pc = pc;
  assign pred_pc = pc;
  assign pred_inst = hit_inst;

  // no packet goes out on a redirect cycle
  assign fetch_valid = hit && !redirect.valid;
  assign fetch_pkt = '{pc: pc, next_pc: pred_next_pc, inst: hit_inst};

  // a stale refill is dropped and idle looks at the pc again
  assign fill_valid = (state == FETCH_INTERACTING) && line_resp_valid && pc_in_line;
  assign fill_addr = req_addr;
  assign fill_line = line_resp.line;

  assign line_req = '{addr: req_addr};

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      pc <= RESET_PC;
    end else if (redirect.valid) begin
      pc <= redirect.target;
    end else if (fetch_valid && fetch_ready) begin
      pc <= pred_next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= FETCH_IDLE;
      line_req_valid <= 1'b0;
    end else begin
      unique case (state)
        FETCH_IDLE: begin
          if (!hit && !redirect.valid) begin
            line_req_valid <= 1'b1;
            state <= FETCH_INTERACTING;
          end
        end
        FETCH_INTERACTING: begin
          // a redirect does not abort the refill in flight
          if (line_resp_valid) begin
            line_req_valid <= 1'b0;
            state <= FETCH_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH_IDLE && !hit && !redirect.valid) begin
      req_addr <= pc_line_base;
    end
  end

endmodule

// ==== src/br_predictor.sv ====
module br_predictor
  import cpu_pkg::*;
(
  input  addr_t pred_pc,
  input  inst_t pred_inst,
  output addr_t pred_next_pc
);

  opcode_e opcode;
  addr_t   imm_j;
  addr_t   imm_b;
  addr_t   seq_pc;

  assign opcode = opcode_e'(pred_inst[6:0]);

  // sign-extended J-type immediate with bit 0 always zero
  assign imm_j = {{12{pred_inst[31]}}, pred_inst[19:12], pred_inst[20],
                  pred_inst[30:21], 1'b0};

  // B-type immediate
  assign imm_b = {{20{pred_inst[31]}}, pred_inst[7], pred_inst[30:25],
                  pred_inst[11:8], 1'b0};

  assign seq_pc = pred_pc + addr_t'(4);

  always_comb begin
    case (opcode)
      OP_JAL: begin
        pred_next_pc = pred_pc + imm_j;
      end
      OP_BRANCH: begin
        // backward branches are taken and forward ones fall through
        if (pred_inst[31]) begin
          pred_next_pc = pred_pc + imm_b;
        end else begin
          pred_next_pc = seq_pc;
        end
      end
      default: begin
        pred_next_pc = seq_pc;
      end
    endcase
  end

endmodule

// ==== src/fetch_frontend.sv ====
module fetch_frontend
  import cpu_pkg::*;
  import mem_pkg::*;
#(
  parameter int    CACHE_INDEX_BITS = 3,
  parameter addr_t RESET_PC = '0
) (
  input  logic       clk,
  input  logic       reset_from_rob_bus,
  input  redirect_t  redirect,
  output logic       fetch_valid,
  output fetch_pkt_t fetch_pkt,
  input  logic       fetch_ready,
  output logic       arvalid,
  output axi_ar_t    ar,
  input  logic       arready,
  input  logic       rvalid,
  input  axi_r_t     r,
  output logic       rready
);

  addr_t      pred_pc;
  inst_t      pred_inst;
  addr_t      pred_next_pc;
  addr_t      lookup_pc;
  logic       hit;
  inst_t      hit_inst;
  logic       fill_valid;
  addr_t      fill_addr;
  line_t      fill_line;
  logic       line_req_valid;
  line_req_t  line_req;
  logic       line_resp_valid;
  line_resp_t line_resp;

  inst_fetcher #(
    .CACHE_INDEX_BITS(CACHE_INDEX_BITS),
    .RESET_PC(RESET_PC)
  ) inst_fetcher_inst (
    .clk, .reset_from_rob_bus, .redirect,
    .fetch_valid, .fetch_pkt, .fetch_ready,
    .pred_pc, .pred_inst, .pred_next_pc,
    .lookup_pc, .hit, .hit_inst,
    .fill_valid, .fill_addr, .fill_line,
    .line_req_valid, .line_req, .line_resp_valid, .line_resp
  );

  icache_store #(
    .CACHE_INDEX_BITS(CACHE_INDEX_BITS)
  ) icache_store_inst (
    .clk, .reset_from_rob_bus, .lookup_pc, .hit, .hit_inst,
    .fill_valid, .fill_addr, .fill_line
  );

  br_predictor br_predictor_inst (
    .pred_pc, .pred_inst, .pred_next_pc
  );

  mem_ctrler mem_ctrler_inst (
    .clk, .reset_from_rob_bus,
    .line_req_valid, .line_req, .line_resp_valid, .line_resp,
    .arvalid, .ar, .arready, .rvalid, .r, .rready
  );

endmodule

// ==== src/mem_ctrler.sv ====
module mem_ctrler
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       reset_from_rob_bus,
  input  logic       line_req_valid,
  input  line_req_t  line_req,
  output logic       line_resp_valid,
  output line_resp_t line_resp,
  output logic       arvalid,
  output axi_ar_t    ar,
  input  logic       arready,
  input  logic       rvalid,
  input  axi_r_t     r,
  output logic       rready
);

  localparam int BEAT_W = $clog2(LINE_WORDS);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(LINE_WORDS - 1);

  mem_state_e        state;
  logic [BEAT_W-1:0] beat;
  mem_addr_t         base_addr;
  line_t             line_buf;

  assign arvalid = (state == MEM_ADDR);
  assign ar = '{araddr: base_addr + mem_addr_t'({beat, 2'b00})};
  assign rready = (state == MEM_DATA);

  assign line_resp = '{line: line_buf};

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= MEM_IDLE;
      beat <= '0;
      line_resp_valid <= 1'b0;
    end else begin
      line_resp_valid <= 1'b0;
      unique case (state)
        MEM_IDLE: begin
          // the request is still high in the response cycle and starts no new line
          if (line_req_valid && !line_resp_valid) begin
            beat <= '0;
            state <= MEM_ADDR;
          end
        end
        MEM_ADDR: begin
          if (arready) begin
            state <= MEM_DATA;
          end
        end
        MEM_DATA: begin
          if (rvalid) begin
            if (beat == LAST_BEAT) begin
              line_resp_valid <= 1'b1;
              state <= MEM_IDLE;
            end else begin
              beat <= beat + 1'b1;
              state <= MEM_ADDR;
            end
          end
        end
        default: begin
          state <= MEM_IDLE;
        end
      endcase
    end
  end

  // payload path with rresp ignored
  always_ff @(posedge clk) begin
    if (state == MEM_IDLE && line_req_valid && !line_resp_valid) begin
      base_addr <= line_req.addr;
    end
    if (state == MEM_DATA && rvalid) begin
      line_buf[{beat, 5'd0} +: 32] <= r.rdata;
    end
  end

endmodule

// ==== tb/fetch_frontend_assert.sv ====
module fetch_frontend_assert
  import cpu_pkg::*;
  import mem_pkg::*;
(
  input logic       clk,
  input logic       reset_from_rob_bus,
  input redirect_t  redirect,
  input logic       fetch_valid,
  input fetch_pkt_t fetch_pkt,
  input logic       fetch_ready,
  input logic       arvalid,
  input axi_ar_t    ar,
  input logic       arready
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of assertion failures so far
  int fail_count = 0;

  // AR master holds its request until accepted
  ar_hold: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    arvalid && !arready |=> arvalid && $stable(ar))
    else begin
      $error("arvalid dropped or ar changed before arready");
      fail_count++;
    end

  // a stalled packet holds unless the ROB redirects
  pkt_hold: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    fetch_valid && !fetch_ready |=> redirect.valid || (fetch_valid && $stable(fetch_pkt)))
    else begin
      $error("fetch packet changed while stalled by the issuer");
      fail_count++;
    end

  // first reset cycle still has unknown state
  quiet_in_reset: assert property (@(posedge clk)
    reset_from_rob_bus && $past(reset_from_rob_bus) |-> !arvalid && !fetch_valid)
    else begin
      $error("arvalid or fetch_valid high during reset");
      fail_count++;
    end

endmodule

bind fetch_frontend fetch_frontend_assert fetch_frontend_assert_inst (.*);

// ==== tb/tb_fetch_frontend.sv ====
module tb_fetch_frontend
  import cpu_pkg::*;
  import mem_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS = 256;
  localparam int NUM_PKTS = 106;
  // every packet may need a full four beat refill at worst-case delays
  localparam int CYCLE_LIMIT = NUM_PKTS * (4 * 16 + 4) + 1000;

  logic       clk = 1'b0;
  logic       reset_from_rob_bus = 1'b1;
  redirect_t  redirect = '0;
  logic       fetch_valid;
  fetch_pkt_t fetch_pkt;
  logic       fetch_ready = 1'b0;
  logic       arvalid;
  axi_ar_t    ar;
  logic       arready = 1'b0;
  logic       rvalid = 1'b0;
  axi_r_t     r = '0;
  logic       rready;

  inst_t       mem [MEM_WORDS];
  logic [15:0] lfsr_state = 16'd53383;
  addr_t       exp_pc = '0;
  int          error_count = 0;
  int          check_count = 0;
  int          pkt_count = 0;
  int          cycle_count = 0;
  int          tests_failed = 0;

  // model cache with index addr[6:4] and tag addr[31:7]
  logic [24:0] model_tag [8];
  logic [7:0]  model_valid = '0;

  // AXI slave state
  int    ar_wait = 0;
  int    r_wait = 0;
  int    ar_beat = 0;
  logic  r_pending = 1'b0;
  addr_t ar_base = '0;
  addr_t rd_addr = '0;

  fetch_frontend fetch_frontend_inst (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // JAL and backward branches are taken and all else goes to pc + 4
  function automatic addr_t predict_next(input addr_t pc, input inst_t inst);
    logic [20:0] off_j;
    logic [12:0] off_b;
    off_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    off_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    if (inst[6:0] == OP_JAL) begin
      return pc + {{11{off_j[20]}}, off_j};
    end
    if (inst[6:0] == OP_BRANCH && off_b[12]) begin
      return pc + {{19{1'b1}}, off_b};
    end
    return pc + 32'd4;
  endfunction

  function automatic inst_t make_jal(input int offset);
    logic [20:0] o;
    o = offset[20:0];
    return {o[20], o[10:1], o[11], o[19:12], 5'd0, OP_JAL};
  endfunction

  // beq x0, x0 with the given offset
  function automatic inst_t make_branch(input int offset);
    logic [12:0] o;
    o = offset[12:0];
    return {o[12], o[10:5], 5'd0, 5'd0, 3'd0, o[4:1], o[11], OP_BRANCH};
  endfunction

  function automatic logic model_hit(input addr_t addr);
    return model_valid[addr[6:4]] && (model_tag[addr[6:4]] == addr[31:7]);
  endfunction

  task automatic report_mismatch(input string name, input addr_t got, input addr_t want);
    $display("Mismatch %s: got %h expected %h", name, got, want);
    error_count++;
  endtask

  task automatic report_error(input string text);
    $display("%s", text);
    error_count++;
  endtask

  // bound checker failures count as errors too
  function automatic int total_errors();
    return error_count + fetch_frontend_inst.fetch_frontend_assert_inst.fail_count;
  endfunction

  // compare every accepted packet against the reference stream
  always @(posedge clk) begin : compare_blk
    inst_t want_inst;
    addr_t want_next;
    if (!reset_from_rob_bus && fetch_valid && fetch_ready) begin
      want_inst = mem[exp_pc[9:2]];
      want_next = predict_next(exp_pc, want_inst);
      check_count++;
      if (fetch_pkt.pc !== exp_pc) begin
        report_mismatch("fetch_pkt.pc", fetch_pkt.pc, exp_pc);
      end
      if (fetch_pkt.inst !== want_inst) begin
        report_mismatch("fetch_pkt.inst", fetch_pkt.inst, want_inst);
      end
      if (fetch_pkt.next_pc !== want_next) begin
        report_mismatch("fetch_pkt.next_pc", fetch_pkt.next_pc, want_next);
      end
      if (!model_hit(exp_pc)) begin
        report_error($sformatf("packet at pc %h came from a line that was never refilled",
                               exp_pc));
      end
      exp_pc = want_next;
      pkt_count++;
    end
  end

  task automatic check_ar(input addr_t addr);
    check_count++;
    if (ar_beat == 0) begin
      ar_base = addr;
      if (addr[3:0] != 4'h0) begin
        report_error($sformatf("AR line address %h is not line aligned", addr));
      end
      if (model_hit(addr)) begin
        report_error($sformatf("AR issued for line %h that is still resident", addr));
      end
    end else if (addr !== ar_base + addr_t'(4 * ar_beat)) begin
      report_mismatch("ar.araddr", addr, ar_base + addr_t'(4 * ar_beat));
    end
  endtask

  // AXI4-Lite read slave with 0 to 7 cycles of delay on arready and rvalid
  always @(posedge clk) begin
    if (reset_from_rob_bus) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      r_pending = 1'b0;
      ar_beat = 0;
      ar_wait = lfsr_bits(3);
    end else if (!r_pending) begin
      if (rready) begin
        report_error("rready is high with no read address accepted");
      end
      if (arvalid && arready) begin
        check_ar(ar.araddr);
        rd_addr = ar.araddr;
        arready <= 1'b0;
        r_pending = 1'b1;
        r_wait = lfsr_bits(3);
      end else if (arvalid) begin
        if (ar_wait == 0) begin
          arready <= 1'b1;
        end else begin
          ar_wait--;
        end
      end
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      r_pending = 1'b0;
      ar_wait = lfsr_bits(3);
      // the line is kept only if the pc still lies in it
      if (ar_beat == 3 && exp_pc[31:4] == ar_base[31:4]) begin
        model_valid[ar_base[6:4]] = 1'b1;
        model_tag[ar_base[6:4]] = ar_base[31:7];
      end
      ar_beat = (ar_beat + 1) % 4;
    end else if (!rvalid) begin
      if (r_wait == 0) begin
        rvalid <= 1'b1;
        r <= '{rdata: mem[rd_addr[9:2]], rresp: 2'b00};
      end else begin
        r_wait--;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped delivering packets", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic run_packets(input int n, input bit random_ready);
    int done;
    done = 0;
    while (done < n) begin
      @(posedge clk);
      if (fetch_valid && fetch_ready) begin
        done++;
      end
      if (done < n) begin
        fetch_ready <= random_ready ? (lfsr_bits(1) != 0) : 1'b1;
      end else begin
        fetch_ready <= 1'b0;
      end
    end
  endtask

  task automatic wait_hit();
    do @(posedge clk); while (!fetch_valid);
  endtask

  task automatic do_redirect(input addr_t target);
    @(posedge clk);
    redirect <= '{valid: 1'b1, target: target};
    exp_pc = target;
    @(posedge clk);
    redirect <= '0;
  endtask

  task automatic end_test(input int num, input string name, input int err_start);
    if (total_errors() == err_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, total_errors() - err_start);
      tests_failed++;
    end
  endtask

  initial begin
    int err_start;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = lfsr_bits(32);
      // random words stay straight-line ALU ops
      mem[i][6:0] = OP_IMM;
    end
    mem[32'h040 >> 2] = make_jal(32'h80);
    mem[32'h0DC >> 2] = make_branch(-32'h1C);
    mem[32'h31C >> 2] = make_jal(32'h64);
    mem[32'h388 >> 2] = make_branch(-32'h88);

    err_start = total_errors();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      if (i >= 2 && (fetch_valid !== 1'b0 || arvalid !== 1'b0 || rready !== 1'b0)) begin
        report_error("fetch_valid, arvalid or rready is high during reset");
      end
    end
    reset_from_rob_bus <= 1'b0;
    @(posedge clk);
    if (fetch_valid !== 1'b0 || arvalid !== 1'b0 || rready !== 1'b0) begin
      report_error("fetch_valid, arvalid or rready is high just after reset");
    end
    run_packets(1, 1'b0);
    end_test(1, "reset", err_start);

    err_start = total_errors();
    run_packets(15, 1'b0);
    end_test(2, "straight-line cold misses", err_start);

    err_start = total_errors();
    run_packets(20, 1'b0);
    end_test(3, "prediction", err_start);

    err_start = total_errors();
    wait_hit();
    do_redirect(32'h100);
    run_packets(40, 1'b1);
    end_test(4, "issuer back-pressure", err_start);

    // the second redirect lands while line 0x240 is refilling and the new path walks into it later
    err_start = total_errors();
    wait_hit();
    do_redirect(32'h240);
    do @(posedge clk); while (!(arvalid && ar.araddr[31:4] == 28'h0000024));
    do_redirect(32'h230);
    run_packets(8, 1'b0);
    end_test(5, "redirect during refill", err_start);

    err_start = total_errors();
    wait_hit();
    do_redirect(32'h300);
    run_packets(22, 1'b0);
    end_test(6, "cache reuse and conflict", err_start);

    $display("tests 6, failed %0d, checks %0d, packets %0d, errors %0d",
             tests_failed, check_count, pkt_count, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
